// ==== rtl/dispatch_consts.svh ====
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// datapath and pc width
`define XLEN 32

// architectural register index
`define REG_ADDR_W 5

// ROB sizing, tag is log2 of the depth
`define ROB_DEPTH 8
`define ROB_TAG_W $clog2(`ROB_DEPTH)

// instruction field widths
`define OPCODE_W 7
`define FUNCT3_W 3
`define FUNCT7_W 7

// funct7 of op-reg that selects the M extension
`define FUNCT7_MULDIV 7'b0000001

// number of reservation stations fed by dispatch
`define NUM_STATIONS 4

`endif

// ==== rtl/dispatch_pkg.sv ====
`include "dispatch_consts.svh"

package dispatch_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [`ROB_TAG_W-1:0]  rob_tag_t;

    // base opcodes of RV32IM
    typedef enum logic [`OPCODE_W-1:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011
    } opcode_e;

    // funct3 of op-imm, shifts take shamt instead of the i immediate
    typedef enum logic [`FUNCT3_W-1:0] {
        arith_f3_add  = 3'b000,
        arith_f3_sll  = 3'b001,
        arith_f3_slt  = 3'b010,
        arith_f3_sltu = 3'b011,
        arith_f3_xor  = 3'b100,
        arith_f3_sr   = 3'b101,
        arith_f3_or   = 3'b110,
        arith_f3_and  = 3'b111
    } arith_f3_e;

    typedef enum logic [2:0] {
        st_none,
        st_alu,
        st_mul_div,
        st_load_store,
        st_branch
    } station_e;

    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t pc_next;
    } fetch_pkt_t;

    typedef struct packed {
        rob_tag_t tag;
        word_t    data;
        logic     ready;
    } rat_read_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } commit_t;

    typedef struct packed {
        rob_tag_t tag;
        word_t    data;
        logic     ready;
    } operand_t;

    typedef struct packed {
        logic alu;
        logic mul_div;
        logic load_store;
        logic branch;
    } station_full_t;

    typedef struct packed {
        logic alu;
        logic mul_div;
        logic load_store;
        logic branch;
    } station_valid_t;

    typedef struct packed {
        station_e station;
        logic     legal;
        logic     uses_rs1;
        logic     uses_rs2;
        logic     writes_rd;
        logic     a_is_pc;
        logic     b_is_imm;
        logic     needs_load_queue;
        logic     needs_store_queue;
        logic     pc_next_valid;
        word_t    imm;
    } decoded_t;

    typedef struct packed {
        word_t    instr;
        rob_tag_t tag_dest;
        operand_t src_a;
        operand_t src_b;
        word_t    imm;
        word_t    pc;
    } rs_entry_t;

    typedef struct packed {
        word_t    instr;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     regf_we;
        word_t    pc;
        word_t    pc_next;
        logic     pc_next_valid;
    } rob_entry_t;

endpackage

// ==== rtl/instr_field_decode.sv ====
`include "dispatch_consts.svh"

module instr_field_decode
    import dispatch_pkg::*;
(
    input  word_t    instr,
    output decoded_t dec,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    output reg_idx_t rd_idx
);

    opcode_e              opcode;
    arith_f3_e            funct3;
    logic [`FUNCT7_W-1:0] funct7;
    logic                 is_shift;

    word_t i_imm;
    word_t s_imm;
    word_t b_imm;
    word_t u_imm;
    word_t j_imm;
    word_t shamt;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = arith_f3_e'(instr[14:12]);
    assign funct7 = instr[31:25];

    // immediates, all sign extended from bit 31 except u and shamt
    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign shamt = {{(`XLEN-5){1'b0}}, instr[24:20]};

    assign is_shift = (funct3 == arith_f3_sll) || (funct3 == arith_f3_sr);

    always_comb begin
        dec               = '0;
        dec.station       = st_none;
        dec.pc_next_valid = 1'b1;

        unique case (opcode)
            op_b_lui: begin
                dec.legal     = 1'b1;
                dec.station   = st_alu;
                dec.writes_rd = 1'b1;
                dec.b_is_imm  = 1'b1;
                dec.imm       = u_imm;
            end
            op_b_auipc: begin
                // pc + upper immediate, pc enters as operand a
                dec.legal     = 1'b1;
                dec.station   = st_alu;
                dec.writes_rd = 1'b1;
                dec.a_is_pc   = 1'b1;
                dec.b_is_imm  = 1'b1;
                dec.imm       = u_imm;
            end
            op_b_jal: begin
                dec.legal         = 1'b1;
                dec.station       = st_branch;
                dec.writes_rd     = 1'b1;
                dec.pc_next_valid = 1'b0;
                dec.imm           = j_imm;
            end
            op_b_jalr: begin
                dec.legal         = 1'b1;
                dec.station       = st_branch;
                dec.uses_rs1      = 1'b1;
                dec.writes_rd     = 1'b1;
                dec.pc_next_valid = 1'b0;
                dec.imm           = i_imm;
            end
            op_b_br: begin
                // compares rs1 with rs2, no destination
                dec.legal         = 1'b1;
                dec.station       = st_branch;
                dec.uses_rs1      = 1'b1;
                dec.uses_rs2      = 1'b1;
                dec.pc_next_valid = 1'b0;
                dec.imm           = b_imm;
            end
            op_b_load: begin
                dec.legal            = 1'b1;
                dec.station          = st_load_store;
                dec.uses_rs1         = 1'b1;
                dec.writes_rd        = 1'b1;
                dec.needs_load_queue = 1'b1;
                dec.imm              = i_imm;
            end
            op_b_store: begin
                dec.legal             = 1'b1;
                dec.station           = st_load_store;
                dec.uses_rs1          = 1'b1;
                dec.uses_rs2          = 1'b1;
                dec.needs_store_queue = 1'b1;
                dec.imm               = s_imm;
            end
            op_b_imm: begin
                dec.legal     = 1'b1;
                dec.station   = st_alu;
                dec.uses_rs1  = 1'b1;
                dec.writes_rd = 1'b1;
                dec.b_is_imm  = 1'b1;
                dec.imm       = is_shift ? shamt : i_imm;
            end
            op_b_reg: begin
                // mul and div share the opcode, funct7 picks the unit
                dec.legal     = 1'b1;
                dec.station   = (funct7 == `FUNCT7_MULDIV) ? st_mul_div : st_alu;
                dec.uses_rs1  = 1'b1;
                dec.uses_rs2  = 1'b1;
                dec.writes_rd = 1'b1;
            end
            default: begin
                dec.legal   = 1'b0;
                dec.station = st_none;
            end
        endcase
    end

    // indices of unused registers read as x0
    assign rs1_idx = dec.uses_rs1  ? instr[19:15] : '0;
    assign rs2_idx = dec.uses_rs2  ? instr[24:20] : '0;
    assign rd_idx  = dec.writes_rd ? instr[11:7]  : '0;

    a_station_legal: assert final ((dec.station == st_none) == !dec.legal)
        else $error("instr_field_decode: station %s with legal %b",
                    dec.station.name(), dec.legal);

endmodule

// ==== rtl/operand_forward.sv ====
module operand_forward
    import dispatch_pkg::*;
(
    input  logic      use_reg,
    input  rat_read_t rat,
    input  commit_t   commit,
    input  word_t     fixed_value,
    output operand_t  opnd
);

    logic commit_hit;

    // value retiring this cycle for the tag we are still waiting on
    assign commit_hit = commit.valid && (commit.tag == rat.tag) && !rat.ready;

    always_comb begin
        if (!use_reg) begin
            opnd.tag   = '0;
            opnd.data  = fixed_value;
            opnd.ready = 1'b1;
        end else if (commit_hit) begin
            opnd.tag   = '0;
            opnd.data  = commit.value;
            opnd.ready = 1'b1;
        end else begin
            // still pending, or already valid in the register file
            opnd.tag   = rat.tag;
            opnd.data  = rat.data;
            opnd.ready = rat.ready;
        end
    end

    a_fixed_ready: assert final (use_reg !== 1'b0 || opnd.ready === 1'b1)
        else $error("operand_forward: fixed operand sent without ready");

endmodule

// ==== rtl/issue_gate.sv ====
module issue_gate
    import dispatch_pkg::*;
(
    input  logic           iq_valid,
    input  decoded_t       dec,
    input  station_full_t  full,
    input  logic           rob_full,
    input  logic           lsq_full,
    input  logic           lsq_load_rs_full,
    output logic           iq_issue,
    output station_valid_t valid,
    output logic           rob_valid
);

    logic target_full;
    logic lsq_block;
    logic issue;

    // full flag of the station this instruction goes to
    always_comb begin
        unique case (dec.station)
            st_alu:        target_full = full.alu;
            st_mul_div:    target_full = full.mul_div;
            st_load_store: target_full = full.load_store;
            st_branch:     target_full = full.branch;
            default:       target_full = 1'b1;
        endcase
    end

    // loads also need room in the load side of the lsq
    assign lsq_block = ((dec.needs_load_queue || dec.needs_store_queue) && lsq_full)
                     || (dec.needs_load_queue && lsq_load_rs_full);

    assign issue = iq_valid && dec.legal && !target_full && !rob_full && !lsq_block;

    always_comb begin
        valid = '0;
        if (issue) begin
            unique case (dec.station)
                st_alu:        valid.alu        = 1'b1;
                st_mul_div:    valid.mul_div    = 1'b1;
                st_load_store: valid.load_store = 1'b1;
                st_branch:     valid.branch     = 1'b1;
                default:       valid            = '0;
            endcase
        end
    end

    assign iq_issue  = issue;
    // rob entry only when the instruction actually leaves the queue
    assign rob_valid = issue;

    a_one_station: assert final ($isunknown({valid, rob_valid, iq_issue})
                                 || ($onehot0(valid)
                                     && ((|valid) == rob_valid)
                                     && (rob_valid == iq_issue)))
        else $error("issue_gate: station valids %b with rob_valid %b, iq_issue %b",
                    valid, rob_valid, iq_issue);

endmodule

// ==== rtl/dispatch_stage.sv ====
module dispatch_stage
    import dispatch_pkg::*;
(
    // instruction queue
    input  fetch_pkt_t     fetch,
    input  logic           iq_valid,
    output logic           iq_issue,

    // register file
    input  rat_read_t      rat_rs1,
    input  rat_read_t      rat_rs2,
    input  rob_tag_t       rd_tag,
    output reg_idx_t       rs1_idx,
    output reg_idx_t       rs2_idx,

    // rob
    input  commit_t        commit,
    input  logic           rob_full,
    output logic           rob_valid,
    output rob_entry_t     rob_entry,

    // reservation stations and lsq
    input  station_full_t  full,
    input  logic           lsq_full,
    input  logic           lsq_load_rs_full,
    output station_valid_t rs_valid,
    output rs_entry_t      rs_entry
);

    decoded_t dec;
    reg_idx_t rd_idx;
    word_t    fixed_a;
    word_t    fixed_b;
    operand_t opnd_a;
    operand_t opnd_b;

    instr_field_decode u_decode (
        .instr   (fetch.instr),
        .dec     (dec),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rd_idx  (rd_idx)
    );

    // values used when a source is not a register
    assign fixed_a = dec.a_is_pc  ? fetch.pc : '0;
    assign fixed_b = dec.b_is_imm ? dec.imm  : '0;

    operand_forward a_fwd (
        .use_reg     (dec.uses_rs1),
        .rat         (rat_rs1),
        .commit      (commit),
        .fixed_value (fixed_a),
        .opnd        (opnd_a)
    );

    operand_forward b_fwd (
        .use_reg     (dec.uses_rs2),
        .rat         (rat_rs2),
        .commit      (commit),
        .fixed_value (fixed_b),
        .opnd        (opnd_b)
    );

    issue_gate u_gate (
        .iq_valid         (iq_valid),
        .dec              (dec),
        .full             (full),
        .rob_full         (rob_full),
        .lsq_full         (lsq_full),
        .lsq_load_rs_full (lsq_load_rs_full),
        .iq_issue         (iq_issue),
        .valid            (rs_valid),
        .rob_valid        (rob_valid)
    );

    // entry payloads, qualified by rs_valid and rob_valid
    always_comb begin
        rs_entry.instr    = fetch.instr;
        rs_entry.tag_dest = rd_tag;
        rs_entry.src_a    = opnd_a;
        rs_entry.src_b    = opnd_b;
        rs_entry.imm      = dec.imm;
        rs_entry.pc       = fetch.pc;
    end

    always_comb begin
        rob_entry.instr         = fetch.instr;
        rob_entry.rs1           = rs1_idx;
        rob_entry.rs2           = rs2_idx;
        rob_entry.rd            = rd_idx;
        rob_entry.regf_we       = dec.writes_rd;
        rob_entry.pc            = fetch.pc;
        rob_entry.pc_next       = fetch.pc_next;
        // jumps and branches resolve their next pc later
        rob_entry.pc_next_valid = dec.pc_next_valid;
    end

endmodule

// ==== tb/dispatch_tb_checks.svh ====
`ifndef DISPATCH_TB_CHECKS_SVH
`define DISPATCH_TB_CHECKS_SVH

// outputs settle in the cycle the inputs were driven, checked at the next edge
task automatic note_mismatch(input string what, input logic [255:0] exp_v,
                             input logic [255:0] act_v);
    errors++;
    $display("CHECK FAILED %s (%s): expected %0h, actual %0h",
             checked_name, what, exp_v, act_v);
endtask

a_issue: assert property (@(posedge clk) disable iff (reset)
    iq_issue == exp_issue)
    else note_mismatch("iq_issue", $sampled(exp_issue), $sampled(iq_issue));

a_rob_valid: assert property (@(posedge clk) disable iff (reset)
    rob_valid == exp_issue)
    else note_mismatch("rob_valid", $sampled(exp_issue), $sampled(rob_valid));

a_station: assert property (@(posedge clk) disable iff (reset)
    rs_valid == exp_valid)
    else note_mismatch("rs_valid", $sampled(exp_valid), $sampled(rs_valid));

a_read_idx: assert property (@(posedge clk) disable iff (reset)
    {rs1_idx, rs2_idx} == {exp_rs1_idx, exp_rs2_idx})
    else note_mismatch("read indices", $sampled({exp_rs1_idx, exp_rs2_idx}),
                       $sampled({rs1_idx, rs2_idx}));

a_rs_entry: assert property (@(posedge clk) disable iff (reset)
    rs_entry == exp_rs_entry)
    else note_mismatch("rs_entry", $sampled(exp_rs_entry), $sampled(rs_entry));

a_rob_entry: assert property (@(posedge clk) disable iff (reset)
    rob_entry == exp_rob_entry)
    else note_mismatch("rob_entry", $sampled(exp_rob_entry), $sampled(rob_entry));

`endif

// ==== tb/dispatch_tb.sv ====
module dispatch_tb
    import dispatch_pkg::*;
;
    localparam int LIMIT = 16 + 600 + 50;

    logic clk = 1'b0;
    logic reset;
    fetch_pkt_t fetch;
    logic iq_valid, rob_full, lsq_full, lsq_load_rs_full;
    rat_read_t rat_rs1, rat_rs2;
    rob_tag_t rd_tag;
    commit_t commit;
    station_full_t full;
    logic iq_issue, rob_valid;
    reg_idx_t rs1_idx, rs2_idx, exp_rs1_idx, exp_rs2_idx;
    station_valid_t rs_valid, exp_valid;
    rs_entry_t rs_entry, exp_rs_entry;
    rob_entry_t rob_entry, exp_rob_entry;
    decoded_t m_dec;
    logic exp_issue;
    integer seed = 32'he5d7;
    int errors = 0;
    int cycles = 0;
    string test_name = "reset";
    string checked_name = "reset";

    dispatch_stage dut (.*);

    always #20 clk = ~clk;
    always @(negedge clk) checked_name = test_name;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // R format field layout shared by the other formats
    function automatic word_t enc(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // reference decode straight from the RV32IM encoding tables
    function automatic decoded_t model_decode(input word_t i);
        decoded_t d;
        d = '0;
        d.pc_next_valid = 1'b1;
        d.legal = 1'b1;
        case (i[6:0])
            7'h37: {d.station, d.writes_rd, d.b_is_imm, d.imm} = {st_alu, 2'b11, i[31:12], 12'h0};
            7'h17: begin
                {d.station, d.writes_rd, d.b_is_imm, d.a_is_pc} = {st_alu, 3'b111};
                d.imm = {i[31:12], 12'h0};
            end
            7'h6f: begin
                {d.station, d.writes_rd, d.pc_next_valid} = {st_branch, 2'b10};
                d.imm = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            end
            7'h67: begin
                {d.station, d.writes_rd, d.uses_rs1, d.pc_next_valid} = {st_branch, 3'b110};
                d.imm = {{20{i[31]}}, i[31:20]};
            end
            7'h63: begin
                {d.station, d.uses_rs1, d.uses_rs2, d.pc_next_valid} = {st_branch, 3'b110};
                d.imm = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            end
            7'h03: begin
                {d.station, d.uses_rs1, d.writes_rd, d.needs_load_queue} = {st_load_store, 3'b111};
                d.imm = {{20{i[31]}}, i[31:20]};
            end
            7'h23: begin
                {d.station, d.uses_rs1, d.uses_rs2, d.needs_store_queue} = {st_load_store, 3'b111};
                d.imm = {{20{i[31]}}, i[31:25], i[11:7]};
            end
            7'h13: begin
                {d.station, d.uses_rs1, d.writes_rd, d.b_is_imm} = {st_alu, 3'b111};
                if (i[13:12] == 2'b01)
                    d.imm = {27'h0, i[24:20]};
                else
                    d.imm = {{20{i[31]}}, i[31:20]};
            end
            7'h33: begin
                {d.uses_rs1, d.uses_rs2, d.writes_rd} = 3'b111;
                d.station = (i[31:25] == 7'h01) ? st_mul_div : st_alu;
            end
            default: d.legal = 1'b0;
        endcase
        return d;
    endfunction

    function automatic operand_t model_operand(input logic use_reg, input rat_read_t r,
                                               input commit_t c, input word_t fixed_v);
        if (!use_reg)
            return '{tag: '0, data: fixed_v, ready: 1'b1};
        if (c.valid && c.tag == r.tag && !r.ready)
            return '{tag: '0, data: c.value, ready: 1'b1};
        return '{tag: r.tag, data: r.data, ready: r.ready};
    endfunction

    always_comb begin
        logic blocked;
        m_dec = model_decode(fetch.instr);
        exp_rs1_idx = m_dec.uses_rs1 ? fetch.instr[19:15] : '0;
        exp_rs2_idx = m_dec.uses_rs2 ? fetch.instr[24:20] : '0;
        case (m_dec.station)
            st_alu:        blocked = full.alu;
            st_mul_div:    blocked = full.mul_div;
            st_load_store: blocked = full.load_store || lsq_full
                                     || (m_dec.needs_load_queue && lsq_load_rs_full);
            st_branch:     blocked = full.branch;
            default:       blocked = 1'b1;
        endcase
        exp_issue = iq_valid && !blocked && !rob_full;
        exp_valid = '0;
        exp_valid.alu = exp_issue && m_dec.station == st_alu;
        exp_valid.mul_div = exp_issue && m_dec.station == st_mul_div;
        exp_valid.load_store = exp_issue && m_dec.station == st_load_store;
        exp_valid.branch = exp_issue && m_dec.station == st_branch;
        exp_rs_entry = '{fetch.instr, rd_tag,
            model_operand(m_dec.uses_rs1, rat_rs1, commit, m_dec.a_is_pc ? fetch.pc : '0),
            model_operand(m_dec.uses_rs2, rat_rs2, commit, m_dec.b_is_imm ? m_dec.imm : '0),
            m_dec.imm, fetch.pc};
        exp_rob_entry = '{fetch.instr, exp_rs1_idx, exp_rs2_idx,
            m_dec.writes_rd ? fetch.instr[11:7] : 5'd0, m_dec.writes_rd,
            fetch.pc, fetch.pc_next, m_dec.pc_next_valid};
    end

    `include "dispatch_tb_checks.svh"

    // commit mode picks no commit (0), an rs1 hit (1), an rs2 hit (2),
    // one tag shared by both (3) or a random bus (4)
    task automatic send(input string name, input word_t instr, input logic iv,
                        input logic [3:0] f, input logic [2:0] rf_lf_llf,
                        input int cmode, input logic [1:0] rdy);
        word_t pc;
        @(posedge clk);
        pc = $random(seed) & 32'hffff_fffc;
        test_name <= name;
        fetch <= '{instr, pc, pc + 4};
        iq_valid <= iv;
        full <= f;
        {rob_full, lsq_full, lsq_load_rs_full} <= rf_lf_llf;
        rd_tag <= $random(seed);
        rat_rs1 <= '{3'd2, $random(seed), rdy[1]};
        rat_rs2 <= '{(cmode == 3) ? 3'd2 : 3'd5, $random(seed), rdy[0]};
        case (cmode)
            0: commit <= '{1'b0, 3'd2, $random(seed)};
            1, 3: commit <= '{1'b1, 3'd2, $random(seed)};
            2: commit <= '{1'b1, 3'd5, $random(seed)};
            default: commit <= '{$random(seed), $random(seed), $random(seed)};
        endcase
    endtask

    function automatic word_t rand_instr();
        logic [6:0] ops [9] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13, 7'h33};
        word_t w;
        int k;
        w = $random(seed);
        k = $unsigned($random(seed)) % 10;
        if (k < 9)
            w[6:0] = ops[k];
        if (k == 8 && w[31] == 1'b0)
            w[31:25] = w[25] ? 7'h01 : 7'h00;
        return w;
    endfunction

    initial begin
        reset = 1'b1;
        fetch = '0;
        iq_valid = 1'b0;
        {rob_full, lsq_full, lsq_load_rs_full} = 3'b000;
        rat_rs1 = '0;
        rat_rs2 = '0;
        rd_tag = '0;
        commit = '0;
        full = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // routing of every class
        send("lui", enc(7'h55, 5'd3, 5'd7, 3'd2, 5'd9, 7'h37), 1, 0, 0, 1, 2'b00);
        send("auipc", enc(7'h40, 5'd1, 5'd2, 3'd3, 5'd4, 7'h17), 1, 0, 0, 0, 2'b00);
        send("jal", enc(7'h7f, 5'd6, 5'd8, 3'd5, 5'd1, 7'h6f), 1, 0, 0, 0, 2'b00);
        send("jalr fwd", enc(7'h01, 5'd2, 5'd3, 3'd0, 5'd1, 7'h67), 1, 0, 0, 1, 2'b00);
        send("jalr ready", enc(7'h01, 5'd2, 5'd3, 3'd0, 5'd1, 7'h67), 1, 0, 0, 1, 2'b10);
        send("branch", enc(7'h60, 5'd4, 5'd5, 3'd1, 5'd17, 7'h63), 1, 0, 0, 2, 2'b00);
        send("load", enc(7'h7e, 5'd9, 5'd10, 3'd2, 5'd11, 7'h03), 1, 0, 0, 1, 2'b00);
        send("store same tag", enc(7'h3f, 5'd9, 5'd10, 3'd2, 5'd11, 7'h23), 1, 0, 0, 3, 2'b00);
        send("store one ready", enc(7'h3f, 5'd9, 5'd10, 3'd2, 5'd11, 7'h23), 1, 0, 0, 3, 2'b01);
        send("addi", enc(7'h70, 5'd31, 5'd1, 3'd0, 5'd2, 7'h13), 1, 0, 0, 0, 2'b00);
        send("slli", enc(7'h00, 5'd13, 5'd1, 3'd1, 5'd2, 7'h13), 1, 0, 0, 0, 2'b00);
        send("srai", enc(7'h20, 5'd7, 5'd1, 3'd5, 5'd2, 7'h13), 1, 0, 0, 0, 2'b00);
        send("add", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd2, 7'h33), 1, 0, 0, 2, 2'b00);
        send("sub", enc(7'h20, 5'd3, 5'd1, 3'd0, 5'd2, 7'h33), 1, 0, 0, 0, 2'b11);
        send("mul", enc(7'h01, 5'd3, 5'd1, 3'd0, 5'd2, 7'h33), 1, 0, 0, 3, 2'b00);
        send("illegal", enc(7'h01, 5'd3, 5'd1, 3'd0, 5'd2, 7'h7f), 1, 0, 0, 0, 2'b00);
        // back-pressure
        send("iq empty", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd2, 7'h33), 0, 0, 0, 0, 2'b00);
        send("rob full", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd2, 7'h33), 1, 0, 3'b100, 0, 2'b00);
        send("alu full", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd2, 7'h33), 1, 4'b1000, 0, 0, 2'b00);
        send("muldiv full", enc(7'h01, 5'd3, 5'd1, 3'd0, 5'd2, 7'h33), 1, 4'b0100, 0, 0, 2'b00);
        send("ls full", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd2, 7'h03), 1, 4'b0010, 0, 0, 2'b00);
        send("br full", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd2, 7'h63), 1, 4'b0001, 0, 0, 2'b00);
        send("other full", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd2, 7'h63), 1, 4'b1110, 0, 0, 2'b00);
        send("lsq full load", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd2, 7'h03), 1, 0, 3'b010, 0, 2'b00);
        send("lsq full store", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd2, 7'h23), 1, 0, 3'b010, 0, 2'b00);
        send("load rs full", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd2, 7'h03), 1, 0, 3'b001, 0, 2'b00);
        send("store rs full", enc(7'h00, 5'd3, 5'd1, 3'd0, 5'd2, 7'h23), 1, 0, 3'b001, 0, 2'b00);
        // random mix with each full flag set about one time in eight
        repeat (500) begin
            send("random", rand_instr(), ($random(seed) & 7) != 0,
                 ($random(seed) & $random(seed) & $random(seed)),
                 ($random(seed) & $random(seed) & $random(seed)),
                 $unsigned($random(seed)) % 5, $random(seed));
        end
        @(posedge clk);
        iq_valid <= 1'b0;
        repeat (2) @(posedge clk);
        $display("dispatch_tb: %0d errors after %0d cycles", errors, cycles);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+rtl
+incdir+tb
rtl/dispatch_pkg.sv
rtl/instr_field_decode.sv
rtl/operand_forward.sv
rtl/issue_gate.sv
rtl/dispatch_stage.sv
tb/dispatch_tb.sv
